// File: hw/gf_alpha_counter.sv
module gf_alpha_counter (
	input logic clk,
	input logic reset,
	input logic alpha_load,
	input logic alpha_step,
	output gf_pkg::gf_elem_t count
);

	// Field LFSR, holds alpha^i after i steps.
	always_ff @(posedge clk) begin
		if (reset || alpha_load)
			count <= gf_pkg::gf_one;
		else if (alpha_step)
			count <= gf_pkg::gf_xtime(count);
	end

endmodule

// File: hw/gf_ctrl.sv
module gf_ctrl (
	input logic clk,
	input logic reset,
	input logic start,
	input gf_pkg::gf_op_t op,
	input gf_pkg::gf_count_t k,
	output logic mul_load,
	output logic mul_step,
	output logic inv_load,
	output logic inv_step,
	output logic alpha_load,
	output logic alpha_step,
	output gf_pkg::gf_op_t sel,
	output logic done,
	output logic busy
);

	gf_pkg::gf_state_t state;
	gf_pkg::gf_count_t cnt; // Steps issued so far.
	gf_pkg::gf_count_t k_q;
	gf_pkg::gf_count_t target;
	logic accept;
	logic stepping;

	////////////////////////////////
	// Handshake and step decode
	////////////////////////////////

	assign busy = (state != gf_pkg::ST_IDLE);
	assign accept = start && !busy; // Start ignored while busy.

	always_comb begin
		case (state)
			gf_pkg::ST_MUL: target = gf_pkg::gf_mul_steps;
			gf_pkg::ST_INV: target = gf_pkg::gf_inv_steps;
			gf_pkg::ST_ALPHA: target = k_q;
			default: target = '0;
		endcase
	end

	// Last cycle of a busy state issues no step; that is the finish cycle.
	assign stepping = busy && (cnt != target);

	assign mul_load = accept && (op == gf_pkg::OP_MUL);
	assign inv_load = accept && (op == gf_pkg::OP_INV);
	assign alpha_load = accept && (op == gf_pkg::OP_ALPHA);

	assign mul_step = stepping && (state == gf_pkg::ST_MUL);
	assign inv_step = stepping && (state == gf_pkg::ST_INV);
	assign alpha_step = stepping && (state == gf_pkg::ST_ALPHA);

	////////////////////////////////
	// State machine
	////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= gf_pkg::ST_IDLE;
			cnt <= '0;
			k_q <= '0;
			sel <= gf_pkg::OP_MUL;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				gf_pkg::ST_IDLE: begin
					if (accept) begin
						cnt <= '0;
						k_q <= k;
						case (op)
							gf_pkg::OP_MUL: begin
								state <= gf_pkg::ST_MUL;
								sel <= op;
							end
							gf_pkg::OP_INV: begin
								state <= gf_pkg::ST_INV;
								sel <= op;
							end
							gf_pkg::OP_ALPHA: begin
								state <= gf_pkg::ST_ALPHA;
								sel <= op;
							end
							default: state <= gf_pkg::ST_IDLE; // Unused opcode.
						endcase
					end
				end
				default: begin
					if (stepping) begin
						cnt <= cnt + 1'b1;
					end else begin
						done <= 1'b1;
						state <= gf_pkg::ST_IDLE;
					end
				end
			endcase
		end
	end

endmodule

// File: hw/gf_inv_datapath.sv
module gf_inv_datapath (
	input logic clk,
	input logic reset,
	input logic inv_load,
	input logic inv_step,
	input gf_pkg::gf_elem_t a,
	output gf_pkg::gf_elem_t inverse
);

	gf_pkg::gf_elem_t sq_q; // a^(2^i)
	gf_pkg::gf_elem_t acc; // Running product of the squares.
	gf_pkg::gf_elem_t sq_in;
	gf_pkg::gf_elem_t sq_out;
	gf_pkg::gf_elem_t acc_out;

	// Squarer sees the operand itself on load, else its own register.
	assign sq_in = inv_load ? a : sq_q;

	gf_parallel_mult u_square (
		.x(sq_in),
		.y(sq_in),
		.p(sq_out)
	);

	gf_parallel_mult u_accum (
		.x(acc),
		.y(sq_q),
		.p(acc_out)
	);

	////////////////////////////////
	// a^2 * a^4 * a^8 * a^16 = a^30
	////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			sq_q <= '0;
			acc <= gf_pkg::gf_one;
		end else if (inv_load) begin
			sq_q <= sq_out;
			acc <= gf_pkg::gf_one;
		end else if (inv_step) begin
			sq_q <= sq_out;
			acc <= acc_out;
		end
	end

	// Zero in gives zero out, since a^2 is already zero.
	assign inverse = acc;

endmodule

// File: hw/gf_parallel_mult.sv
module gf_parallel_mult (
	input gf_pkg::gf_elem_t x,
	input gf_pkg::gf_elem_t y,
	output gf_pkg::gf_elem_t p
);

	////////////////////////////////
	// Reduced shifts of x
	////////////////////////////////

	// xs[i] holds x * alpha^i, already reduced.
	gf_pkg::gf_elem_t xs [gf_pkg::gf_m];

	assign xs[0] = x;

	for (genvar i = 1; i < gf_pkg::gf_m; i++) begin : g_shift
		assign xs[i] = gf_pkg::gf_xtime(xs[i-1]);
	end

	////////////////////////////////
	// Partial product sum
	////////////////////////////////

	always_comb begin
		p = '0;
		for (int i = 0; i < gf_pkg::gf_m; i++) begin
			if (y[i])
				p = p ^ xs[i];
		end
	end

endmodule

// File: hw/gf_pkg.sv
package gf_pkg;

	////////////////////////////////
	// Field constants
	////////////////////////////////

	localparam int gf_m = 5; // GF(2^5)

	typedef logic [gf_m-1:0] gf_elem_t; // Standard basis element.
	typedef logic [4:0] gf_count_t; // Step count or exponent k.

	// x^5 + x^2 + 1, the x^5 term implied.
	localparam gf_elem_t gf_poly = 5'b00101;
	localparam gf_elem_t gf_one = 5'b00001;

	// Steps each operation takes after its load.
	localparam gf_count_t gf_mul_steps = gf_count_t'(gf_m);
	localparam gf_count_t gf_inv_steps = gf_count_t'(gf_m - 1);

	////////////////////////////////
	// Opcodes and controller states
	////////////////////////////////

	typedef enum logic [1:0] {
		OP_MUL = 2'd0,
		OP_INV = 2'd1,
		OP_ALPHA = 2'd2
	} gf_op_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_MUL,
		ST_INV,
		ST_ALPHA
	} gf_state_t;

	// Multiply by alpha, reducing the x^5 term back into the low bits.
	function automatic gf_elem_t gf_xtime(input gf_elem_t x);
		return {x[gf_m-2:0], 1'b0} ^ (gf_poly & {gf_m{x[gf_m-1]}});
	endfunction

endpackage

// File: hw/gf_serial_mult.sv
module gf_serial_mult (
	input logic clk,
	input logic reset,
	input logic mul_load,
	input logic mul_step,
	input gf_pkg::gf_elem_t a,
	input gf_pkg::gf_elem_t b,
	output gf_pkg::gf_elem_t product
);

	gf_pkg::gf_elem_t a_q;
	gf_pkg::gf_elem_t b_sr; // Next bit of b sits at the top.
	gf_pkg::gf_elem_t acc;
	gf_pkg::gf_elem_t acc_next;

	// Horner step, MSB of b first.
	always_comb begin
		acc_next = gf_pkg::gf_xtime(acc);
		if (b_sr[gf_pkg::gf_m-1])
			acc_next = acc_next ^ a_q;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			a_q <= '0;
			b_sr <= '0;
			acc <= '0;
		end else if (mul_load) begin
			a_q <= a;
			b_sr <= b;
			acc <= '0;
		end else if (mul_step) begin
			acc <= acc_next;
			b_sr <= {b_sr[gf_pkg::gf_m-2:0], 1'b0};
		end
	end

	assign product = acc; // Valid after the m-th step.

endmodule

// File: hw/gf_unit.sv
module gf_unit (
	input logic clk,
	input logic reset,
	input logic start,
	input gf_pkg::gf_op_t op,
	input gf_pkg::gf_elem_t a,
	input gf_pkg::gf_elem_t b,
	input gf_pkg::gf_count_t k,
	output gf_pkg::gf_elem_t result,
	output logic done,
	output logic busy
);

	logic mul_load;
	logic mul_step;
	logic inv_load;
	logic inv_step;
	logic alpha_load;
	logic alpha_step;
	logic finish;
	gf_pkg::gf_op_t sel;
	gf_pkg::gf_elem_t product;
	gf_pkg::gf_elem_t inverse;
	gf_pkg::gf_elem_t count;

	gf_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.k(k),
		.mul_load(mul_load),
		.mul_step(mul_step),
		.inv_load(inv_load),
		.inv_step(inv_step),
		.alpha_load(alpha_load),
		.alpha_step(alpha_step),
		.sel(sel),
		.done(done),
		.busy(busy)
	);

	gf_serial_mult u_mult (
		.clk(clk),
		.reset(reset),
		.mul_load(mul_load),
		.mul_step(mul_step),
		.a(a),
		.b(b),
		.product(product)
	);

	gf_inv_datapath u_inv (
		.clk(clk),
		.reset(reset),
		.inv_load(inv_load),
		.inv_step(inv_step),
		.a(a),
		.inverse(inverse)
	);

	gf_alpha_counter u_alpha (
		.clk(clk),
		.reset(reset),
		.alpha_load(alpha_load),
		.alpha_step(alpha_step),
		.count(count)
	);

	////////////////////////////////
	// Result register
	////////////////////////////////

	// Busy with no step issued is the controller's last cycle.
	assign finish = busy && !(mul_step || inv_step || alpha_step);

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
		end else if (finish) begin
			case (sel)
				gf_pkg::OP_MUL: result <= product;
				gf_pkg::OP_INV: result <= inverse;
				gf_pkg::OP_ALPHA: result <= count;
				default: result <= result;
			endcase
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the GF(2^5) unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module gf_unit_tb -f tb.f -o gf_unit_sim

status=0
./obj_dir/gf_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi
if grep -q "TESTS FAILED" sim.log; then
	exit 1
fi
exit 0

// File: tb.f
hw/gf_pkg.sv
hw/gf_ctrl.sv
hw/gf_serial_mult.sv
hw/gf_parallel_mult.sv
hw/gf_inv_datapath.sv
hw/gf_alpha_counter.sv
hw/gf_unit.sv
verif/gf_unit_props.sv
verif/gf_unit_tb.sv

// File: verif/gf_unit_props.sv
module gf_unit_props (
	input logic clk,
	input logic reset,
	input logic start,
	input logic busy,
	input logic done,
	input gf_pkg::gf_elem_t result
);

	logic pending; // Accepted start still waiting for its done.

	always_ff @(posedge clk) begin
		if (reset)
			pending <= 1'b0;
		else if (start && !busy)
			pending <= 1'b1;
		else if (done)
			pending <= 1'b0;
	end

	//////////////////////////////
	// Handshake
	//////////////////////////////

	done_single_cycle: assert property (@(posedge clk) disable iff (reset)
		done |=> !done)
		else $error("done stayed high for more than one cycle");

	idle_after_done: assert property (@(posedge clk) disable iff (reset)
		done && !start |=> !busy)
		else $error("busy high after done with no new start");

	done_follows_start: assert property (@(posedge clk) disable iff (reset)
		done |-> pending)
		else $error("done pulse with no accepted start before it");

	result_held_when_idle: assert property (@(posedge clk) disable iff (reset)
		!busy && !$past(busy) && !$past(reset) |-> $stable(result))
		else $error("result changed while the unit was idle");

endmodule

bind gf_unit gf_unit_props u_props (
	.clk(clk),
	.reset(reset),
	.start(start),
	.busy(busy),
	.done(done),
	.result(result)
);

// File: verif/gf_unit_tb.sv
module gf_unit_tb;

	// Longest op is alpha^31, 33 cycles with its launch, plus a gap of up to 3.
	localparam int op_cycles = 40;
	localparam int op_total = 32 * 32 + 32 + 32 + 2 + 200 + 3;
	localparam int timeout_cycles = op_total * op_cycles + 100;

	logic clk;
	logic reset;
	logic start;
	gf_pkg::gf_op_t op;
	gf_pkg::gf_elem_t a;
	gf_pkg::gf_elem_t b;
	gf_pkg::gf_count_t k;
	gf_pkg::gf_elem_t result;
	logic done;
	logic busy;

	int cycle_count = 0;
	int checks = 0;
	int errors = 0;
	int tests = 0;

	gf_unit uut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.op(op),
		.a(a),
		.b(b),
		.k(k),
		.result(result),
		.done(done),
		.busy(busy)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the tests did not finish within %0d cycles", timeout_cycles);
			$display("TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Shift and add, reducing x^5 as the operand is shifted.
	function automatic gf_pkg::gf_elem_t model_mul(input gf_pkg::gf_elem_t x,
		input gf_pkg::gf_elem_t y);
		gf_pkg::gf_elem_t p;
		gf_pkg::gf_elem_t s;
		p = '0;
		s = x;
		for (int i = 0; i < gf_pkg::gf_m; i++) begin
			if (y[i])
				p = p ^ s;
			if (s[gf_pkg::gf_m-1])
				s = (s << 1) ^ gf_pkg::gf_poly;
			else
				s = s << 1;
		end
		return p;
	endfunction

	// Search for the element whose product with x is one.
	function automatic gf_pkg::gf_elem_t model_inv(input gf_pkg::gf_elem_t x);
		gf_pkg::gf_elem_t inv;
		inv = '0; // Zero has no inverse, the unit returns zero.
		for (int e = 1; e < (1 << gf_pkg::gf_m); e++) begin
			if (model_mul(x, gf_pkg::gf_elem_t'(e)) == 5'd1)
				inv = gf_pkg::gf_elem_t'(e);
		end
		return inv;
	endfunction

	function automatic gf_pkg::gf_elem_t model_alpha(input gf_pkg::gf_count_t n);
		gf_pkg::gf_elem_t p;
		p = 5'd1;
		for (int i = 0; i < int'(n); i++)
			p = model_mul(p, 5'b00010);
		return p;
	endfunction

	function automatic gf_pkg::gf_elem_t model_result(input gf_pkg::gf_op_t op_in,
		input gf_pkg::gf_elem_t a_in, input gf_pkg::gf_elem_t b_in,
		input gf_pkg::gf_count_t k_in);
		case (op_in)
			gf_pkg::OP_MUL: return model_mul(a_in, b_in);
			gf_pkg::OP_INV: return model_inv(a_in);
			default: return model_alpha(k_in);
		endcase
	endfunction

	// Edges from the accepting edge to the one that raises done.
	function automatic int model_latency(input gf_pkg::gf_op_t op_in,
		input gf_pkg::gf_count_t k_in);
		case (op_in)
			gf_pkg::OP_MUL: return gf_pkg::gf_m + 1;
			gf_pkg::OP_INV: return gf_pkg::gf_m;
			default: return int'(k_in) + 1;
		endcase
	endfunction

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_elem(input string name, input gf_pkg::gf_elem_t expected,
		input gf_pkg::gf_elem_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error: %s expected 0x%h, got 0x%h", name, expected, actual);
		end
	endtask

	task automatic check_latency(input string what, input int expected, input int actual);
		checks++;
		if (actual != expected) begin
			errors++;
			$display("Latency of %s was %0d cycles where %0d were expected",
				what, actual, expected);
		end
	endtask

	//////////////////////////////
	// Drive helpers
	//////////////////////////////

	task automatic tick();
		@(posedge clk);
		#10;
	endtask

	task automatic launch(input gf_pkg::gf_op_t op_in, input gf_pkg::gf_elem_t a_in,
		input gf_pkg::gf_elem_t b_in, input gf_pkg::gf_count_t k_in);
		op = op_in;
		a = a_in;
		b = b_in;
		k = k_in;
		start = 1'b1;
		tick(); // Accepting edge.
		start = 1'b0;
	endtask

	task automatic wait_done(output int cycles);
		cycles = 0;
		do begin
			tick();
			cycles++;
		end while (!done);
	endtask

	task automatic run_op(input gf_pkg::gf_op_t op_in, input gf_pkg::gf_elem_t a_in,
		input gf_pkg::gf_elem_t b_in, input gf_pkg::gf_count_t k_in,
		output gf_pkg::gf_elem_t got);
		int lat;
		launch(op_in, a_in, b_in, k_in);
		wait_done(lat);
		got = result;
		check_elem("result", model_result(op_in, a_in, b_in, k_in), got);
		check_latency(op_in.name(), model_latency(op_in, k_in), lat);
	endtask

	task automatic report(input string name, input int checks_before, input int errors_before);
		tests++;
		$display("%s: %0d checks, %0d errors", name, checks - checks_before,
			errors - errors_before);
	endtask

	//////////////////////////////
	// Tests
	//////////////////////////////

	task automatic multiply_all_pairs();
		int c0;
		int e0;
		gf_pkg::gf_elem_t got;
		c0 = checks;
		e0 = errors;
		for (int x = 0; x < 32; x++) begin
			for (int y = 0; y < 32; y++)
				run_op(gf_pkg::OP_MUL, gf_pkg::gf_elem_t'(x), gf_pkg::gf_elem_t'(y), '0, got);
		end
		report("multiply", c0, e0);
	endtask

	task automatic invert_all_elements();
		int c0;
		int e0;
		gf_pkg::gf_elem_t got;
		c0 = checks;
		e0 = errors;
		for (int x = 0; x < 32; x++) begin
			run_op(gf_pkg::OP_INV, gf_pkg::gf_elem_t'(x), '0, '0, got);
			if (x != 0)
				check_elem("a*result", 5'd1, model_mul(gf_pkg::gf_elem_t'(x), got));
		end
		report("invert", c0, e0);
	endtask

	task automatic alpha_powers();
		int c0;
		int e0;
		gf_pkg::gf_elem_t got;
		c0 = checks;
		e0 = errors;
		for (int n = 0; n < 32; n++) begin
			run_op(gf_pkg::OP_ALPHA, '0, '0, gf_pkg::gf_count_t'(n), got);
			if (n == 31)
				check_elem("alpha^31", 5'd1, got); // Order of alpha is 31.
		end
		report("alpha power", c0, e0);
	endtask

	task automatic start_while_busy();
		int c0;
		int e0;
		int lat;
		int extra;
		gf_pkg::gf_elem_t first;
		c0 = checks;
		e0 = errors;
		launch(gf_pkg::OP_MUL, 5'h13, 5'h0b, '0);
		tick();
		op = gf_pkg::OP_MUL; // Second start on the same datapath, should be dropped.
		a = 5'h1f;
		b = 5'h1f;
		k = 5'd3;
		start = 1'b1;
		tick();
		start = 1'b0;
		wait_done(lat);
		check_latency("multiply with a start while busy", gf_pkg::gf_m + 1, lat + 2);
		check_elem("result", model_mul(5'h13, 5'h0b), result);
		first = result;
		extra = 0;
		repeat (10) begin
			tick();
			if (done)
				extra++;
			check_elem("result", first, result);
		end
		checks++;
		if (extra != 0) begin
			errors++;
			$display("The ignored start produced %0d extra done pulses", extra);
		end
		check_flag("busy", 1'b0, busy);
		report("ignored start", c0, e0);
	endtask

	task automatic random_mix();
		int c0;
		int e0;
		int unsigned gap;
		int unsigned pick;
		gf_pkg::gf_op_t op_r;
		gf_pkg::gf_elem_t a_r;
		gf_pkg::gf_elem_t b_r;
		gf_pkg::gf_count_t k_r;
		gf_pkg::gf_elem_t got;
		c0 = checks;
		e0 = errors;
		repeat (200) begin
			gap = $urandom % 4;
			pick = $urandom % 3;
			a_r = gf_pkg::gf_elem_t'($urandom);
			b_r = gf_pkg::gf_elem_t'($urandom);
			k_r = gf_pkg::gf_count_t'($urandom);
			case (pick)
				0: op_r = gf_pkg::OP_MUL;
				1: op_r = gf_pkg::OP_INV;
				default: op_r = gf_pkg::OP_ALPHA;
			endcase
			repeat (gap) tick();
			run_op(op_r, a_r, b_r, k_r, got);
		end
		report("random mix", c0, e0);
	endtask

	task automatic reset_during_op();
		int c0;
		int e0;
		gf_pkg::gf_elem_t got;
		c0 = checks;
		e0 = errors;
		launch(gf_pkg::OP_ALPHA, '0, '0, 5'd20);
		repeat (4) tick();
		check_flag("busy", 1'b1, busy);
		reset = 1'b1;
		repeat (2) tick();
		reset = 1'b0;
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_elem("result", '0, result);
		run_op(gf_pkg::OP_MUL, 5'h1d, 5'h16, '0, got);
		run_op(gf_pkg::OP_ALPHA, '0, '0, 5'd7, got);
		report("reset mid-operation", c0, e0);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int unsigned seed_draw;
		seed_draw = $urandom(60929);
		reset = 1'b1;
		start = 1'b0;
		op = gf_pkg::OP_MUL;
		a = '0;
		b = '0;
		k = '0;
		repeat (8) tick();
		reset = 1'b0;

		multiply_all_pairs();
		invert_all_elements();
		alpha_powers();
		start_while_busy();
		random_mix();
		reset_during_op();

		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
